/* Bender.yml */
package:
  name: core_io_subsystem

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - stream_pkg.sv
      - io_translation_table.sv
      - register_file.sv
      - dma_endpoint.sv
      - core_io_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_top.sv

/* bus_pkg.sv */
// Host side types only; the configuration word layout assumes a 32 bit bus and 8 bit channel count
`include "core_io_defines.svh"

package bus_pkg;

    // One command per cycle: write is a strobe, read is held until accepted
    typedef struct packed {
        logic write;
        logic read;
        logic [`IO_LOGICAL_ADDR_WIDTH-1:0] addr;
        logic [`BUS_DATA_WIDTH-1:0] data;
    } bus_cmd_t;

    typedef struct packed {
        logic valid;
        logic [`BUS_DATA_WIDTH-1:0] data;
    } bus_rsp_t;

    typedef struct packed {
        logic [15:0] program_size;
        logic [7:0] padding;
        logic [`CORE_CHANNEL_WIDTH-1:0] channel_count;
    } config_fields_t;

    // Logical address 0 carries the configuration word, every other address raw data
    typedef union packed {
        logic [`BUS_DATA_WIDTH-1:0] raw;
        config_fields_t fields;
    } config_word_u;

endpackage

/* core_io_defines.svh */
// Sizes are fixed for one core; logical and physical address widths must both cover 64 entries
`ifndef CORE_IO_DEFINES_SVH
`define CORE_IO_DEFINES_SVH

// Width of one core register
`define CORE_DATA_WIDTH 20

// Physical register file depth and its index width
`define CORE_REG_COUNT 64
`define CORE_REG_ADDR_WIDTH 6

// Logical addresses seen by the bus and the DMA stream
`define IO_LOGICAL_ADDR_WIDTH 6

// Channel count field inside the configuration word
`define CORE_CHANNEL_WIDTH 8

// Host bus word, wider than a core register
`define BUS_DATA_WIDTH 32

`endif

/* core_io_subsystem.sv */
// Latency at these ports equals the endpoint's; table loads bypass the endpoint entirely
`include "core_io_defines.svh"

module core_io_subsystem (
    input  logic clock,
    input  logic reset,
    input  bus_pkg::bus_cmd_t bus_cmd,
    output logic bus_read_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    input  stream_pkg::map_write_t map_load,
    input  stream_pkg::dma_write_t dma_write,
    input  stream_pkg::read_req_t read_req,
    output logic dma_read_ready,
    output stream_pkg::read_rsp_t read_rsp
);
    import stream_pkg::*;

    logic [`IO_LOGICAL_ADDR_WIDTH-1:0] write_lookup;
    logic [`IO_LOGICAL_ADDR_WIDTH-1:0] read_lookup;
    logic [`CORE_REG_ADDR_WIDTH-1:0] write_entry;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_entry;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr;
    logic [`CORE_DATA_WIDTH-1:0] read_data;
    reg_write_t reg_write;

    dma_endpoint endpoint (
        .clock          (clock),
        .reset          (reset),
        .bus_cmd        (bus_cmd),
        .bus_read_ready (bus_read_ready),
        .bus_rsp        (bus_rsp),
        .dma_write      (dma_write),
        .read_req       (read_req),
        .dma_read_ready (dma_read_ready),
        .read_rsp       (read_rsp),
        .write_lookup   (write_lookup),
        .read_lookup    (read_lookup),
        .write_entry    (write_entry),
        .read_entry     (read_entry),
        .reg_write      (reg_write),
        .read_addr      (read_addr),
        .read_data      (read_data)
    );

    io_translation_table translation (
        .clock        (clock),
        .reset        (reset),
        .map_load     (map_load),
        .write_lookup (write_lookup),
        .read_lookup  (read_lookup),
        .write_entry  (write_entry),
        .read_entry   (read_entry)
    );

    register_file registers (
        .clock     (clock),
        .reset     (reset),
        .reg_write (reg_write),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

/* dma_endpoint.sv */
// Stream wins both arbitrations; one read in flight; a stream read of address 0 gets no response
`include "core_io_defines.svh"

module dma_endpoint (
    input  logic clock,
    input  logic reset,
    input  bus_pkg::bus_cmd_t bus_cmd,
    output logic bus_read_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    input  stream_pkg::dma_write_t dma_write,
    input  stream_pkg::read_req_t read_req,
    output logic dma_read_ready,
    output stream_pkg::read_rsp_t read_rsp,
    output logic [`IO_LOGICAL_ADDR_WIDTH-1:0] write_lookup,
    output logic [`IO_LOGICAL_ADDR_WIDTH-1:0] read_lookup,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] write_entry,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_entry,
    output stream_pkg::reg_write_t reg_write,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr,
    input  logic [`CORE_DATA_WIDTH-1:0] read_data
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_bus_read,
        state_stream_wait,
        state_stream_read
    } read_state_t;

    read_state_t state;
    logic read_config;
    logic stream_accept;
    logic bus_accept;
    logic write_valid;
    logic [`CORE_REG_ADDR_WIDTH-1:0] write_addr;
    logic [`CORE_DATA_WIDTH-1:0] write_data;
    logic [15:0] program_size;
    logic [`CORE_CHANNEL_WIDTH-1:0] channel_count;
    config_word_u config_in;
    config_word_u config_out;

    // The stream requester owns both lookup ports whenever it is active
    assign write_lookup = dma_write.valid ? dma_write.dest : bus_cmd.addr;
    assign read_lookup  = read_req.valid ? read_req.addr : bus_cmd.addr;
    assign config_in.raw = bus_cmd.data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_valid   <= 1'b0;
            program_size  <= '0;
            channel_count <= '0;
        end else begin
            write_valid <= 1'b0;
            if (dma_write.valid) begin
                write_valid <= (write_entry != '0);
            end else if (bus_cmd.write) begin
                if (bus_cmd.addr == '0) begin
                    program_size  <= config_in.fields.program_size;
                    channel_count <= config_in.fields.channel_count;
                end else begin
                    write_valid <= (write_entry != '0);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dma_write.valid) begin
            write_addr <= write_entry;
            write_data <= dma_write.data;
        end else if (bus_cmd.write) begin
            write_addr <= write_entry;
            write_data <= bus_cmd.data[`CORE_DATA_WIDTH-1:0];
        end
    end

    assign reg_write = '{valid: write_valid, addr: write_addr, data: write_data};

    // Bus ready also drops while a stream request waits, so the stream is always taken first
    assign dma_read_ready = (state == state_idle);
    assign bus_read_ready = (state == state_idle) && !read_req.valid;
    assign stream_accept  = dma_read_ready && read_req.valid;
    assign bus_accept     = bus_read_ready && bus_cmd.read;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= state_idle;
            read_config <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (stream_accept) begin
                        // A request for address 0 is consumed here without a response
                        if (read_req.addr != '0) begin
                            state <= state_stream_wait;
                        end
                    end else if (bus_accept) begin
                        read_config <= (bus_cmd.addr == '0);
                        state       <= state_bus_read;
                    end
                end
                state_stream_wait: state <= state_stream_read;
                default: state <= state_idle;
            endcase
        end
    end

    // Physical address is latched on acceptance and held for the response
    always_ff @(posedge clock) begin
        if (stream_accept || bus_accept) begin
            read_addr <= read_entry;
        end
    end

    always_comb begin
        config_out.fields.program_size  = program_size;
        config_out.fields.padding       = '0;
        config_out.fields.channel_count = channel_count;
    end

    assign bus_rsp.valid  = (state == state_bus_read);
    assign bus_rsp.data   = read_config ? config_out.raw : `BUS_DATA_WIDTH'(read_data);
    assign read_rsp.valid = (state == state_stream_read);
    assign read_rsp.data  = read_data;

endmodule

/* io_translation_table.sv */
// Identity map after reset; entry 0 means unmapped and a load is visible to lookups one cycle later
`include "core_io_defines.svh"

module io_translation_table (
    input  logic clock,
    input  logic reset,
    input  stream_pkg::map_write_t map_load,
    input  logic [`IO_LOGICAL_ADDR_WIDTH-1:0] write_lookup,
    input  logic [`IO_LOGICAL_ADDR_WIDTH-1:0] read_lookup,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] write_entry,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] read_entry
);

    localparam int TABLE_DEPTH = 1 << `IO_LOGICAL_ADDR_WIDTH;

    // One physical register index per logical address
    logic [`CORE_REG_ADDR_WIDTH-1:0] entries [TABLE_DEPTH];

    always_ff @(posedge clock) begin
        if (!reset) begin
            // Transparent map, every logical address points at the same physical number
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                entries[i] <= `CORE_REG_ADDR_WIDTH'(i);
            end
        end else if (map_load.valid) begin
            entries[map_load.logical] <= map_load.physical;
        end
    end

    // Both lookups are combinational so the endpoint can register the result directly
    assign write_entry = entries[write_lookup];
    assign read_entry  = entries[read_lookup];

endmodule

/* register_file.sv */
// Single write port and asynchronous read; register 0 is hard zero and writes to it are dropped
`include "core_io_defines.svh"

module register_file (
    input  logic clock,
    input  logic reset,
    input  stream_pkg::reg_write_t reg_write,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr,
    output logic [`CORE_DATA_WIDTH-1:0] read_data
);

    logic [`CORE_DATA_WIDTH-1:0] registers [`CORE_REG_COUNT];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (reg_write.valid && reg_write.addr != '0) begin
            registers[reg_write.addr] <= reg_write.data;
        end
    end

    // Register 0 reads as zero whatever its storage holds
    assign read_data = (read_addr == '0) ? '0 : registers[read_addr];

endmodule

/* stream_pkg.sv */
// Core side stream types; all strobes here have no back-pressure except read_req_t
`include "core_io_defines.svh"

package stream_pkg;

    // Register write beat from the DMA engine, addressed logically
    typedef struct packed {
        logic valid;
        logic [`IO_LOGICAL_ADDR_WIDTH-1:0] dest;
        logic [`CORE_DATA_WIDTH-1:0] data;
    } dma_write_t;

    // Read request, valid is held until the endpoint accepts it
    typedef struct packed {
        logic valid;
        logic [`IO_LOGICAL_ADDR_WIDTH-1:0] addr;
    } read_req_t;

    typedef struct packed {
        logic valid;
        logic [`CORE_DATA_WIDTH-1:0] data;
    } read_rsp_t;

    // Table load word, physical entry in the upper half and logical address below
    typedef struct packed {
        logic valid;
        logic [`CORE_REG_ADDR_WIDTH-1:0] physical;
        logic [`IO_LOGICAL_ADDR_WIDTH-1:0] logical;
    } map_write_t;

    // Write into the physical register file
    typedef struct packed {
        logic valid;
        logic [`CORE_REG_ADDR_WIDTH-1:0] addr;
        logic [`CORE_DATA_WIDTH-1:0] data;
    } reg_write_t;

endpackage

/* tb_checker.sv */
// Shadow model of table, registers and configuration word; assumes only one read is in flight
`include "core_io_defines.svh"

module tb_checker (
    input  logic clock,
    input  logic reset,
    input  bus_pkg::bus_cmd_t bus_cmd,
    input  logic bus_read_ready,
    input  bus_pkg::bus_rsp_t bus_rsp,
    input  stream_pkg::map_write_t map_load,
    input  stream_pkg::dma_write_t dma_write,
    input  stream_pkg::read_req_t read_req,
    input  logic dma_read_ready,
    input  stream_pkg::read_rsp_t read_rsp,
    output int check_count,
    output int mismatch_count,
    output int protocol_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // A read that has been accepted and is waiting for its response strobe
    typedef struct packed {
        logic busy;
        logic [31:0] due;
        logic [`IO_LOGICAL_ADDR_WIDTH-1:0] logical;
        logic [`CORE_REG_ADDR_WIDTH-1:0] physical;
    } pending_read_t;

    logic [`CORE_REG_ADDR_WIDTH-1:0] table_model [`CORE_REG_COUNT];
    logic [`CORE_DATA_WIDTH-1:0] reg_model [`CORE_REG_COUNT];
    logic [`BUS_DATA_WIDTH-1:0] config_model;
    logic write_pending;
    logic [`CORE_REG_ADDR_WIDTH-1:0] write_addr;
    logic [`CORE_DATA_WIDTH-1:0] write_data;
    logic [31:0] edge_count;
    logic read_idle;
    pending_read_t bus_slot;
    pending_read_t stream_slot;

    initial begin
        check_count    = 0;
        mismatch_count = 0;
        protocol_count = 0;
    end

    // Expected read data for an accepted read, using the physical entry seen at acceptance
    function automatic logic [`BUS_DATA_WIDTH-1:0] expected_read(input pending_read_t slot,
                                                                 input logic to_bus);
        logic [`BUS_DATA_WIDTH-1:0] word;
        word = '0;
        if (to_bus && slot.logical == '0) begin
            word = config_model;
        end else if (slot.physical != '0) begin
            word[`CORE_DATA_WIDTH-1:0] = reg_model[slot.physical];
        end
        return word;
    endfunction

    task automatic compare_ready(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            mismatch_count++;
            $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_response(inout pending_read_t slot, input logic valid,
                                  input logic to_bus, input logic [`BUS_DATA_WIDTH-1:0] actual,
                                  input string name);
        logic [`BUS_DATA_WIDTH-1:0] expected;
        if (valid && !slot.busy) begin
            protocol_count++;
            $display("%0t: response on %s with no read outstanding", $time, name);
        end else if (valid) begin
            check_count++;
            expected = expected_read(slot, to_bus);
            if (edge_count != slot.due) begin
                protocol_count++;
                $display("%0t: response on %s came at the wrong latency", $time, name);
            end
            if (actual !== expected) begin
                mismatch_count++;
                $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            end
            slot.busy = 1'b0;
        end else if (slot.busy && edge_count >= slot.due) begin
            protocol_count++;
            $display("%0t: no response on %s for logical address %0d", $time, name, slot.logical);
            slot.busy = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                table_model[i] = `CORE_REG_ADDR_WIDTH'(i);
                reg_model[i]   = '0;
            end
            config_model  = '0;
            write_pending = 1'b0;
            bus_slot      = '0;
            stream_slot   = '0;
            edge_count    = '0;
        end else begin
            edge_count++;
            // Both readies stay low from acceptance until the response cycle has passed
            read_idle = !bus_slot.busy && !stream_slot.busy;
            compare_ready(dma_read_ready, read_idle, "dma_read_ready");
            compare_ready(bus_read_ready, read_idle && !read_req.valid, "bus_read_ready");
            check_response(bus_slot, bus_rsp.valid, 1'b1, bus_rsp.data, "bus_rsp.data");
            check_response(stream_slot, read_rsp.valid, 1'b0, `BUS_DATA_WIDTH'(read_rsp.data),
                           "read_rsp.data");
            // A write seen on the previous edge reaches the register file on this one
            if (write_pending && write_addr != '0) begin
                reg_model[write_addr] = write_data;
            end
            write_pending = 1'b0;
            if (dma_write.valid) begin
                write_pending = 1'b1;
                write_addr    = table_model[dma_write.dest];
                write_data    = dma_write.data;
            end else if (bus_cmd.write && bus_cmd.addr == '0) begin
                config_model = {bus_cmd.data[31:16], 8'h00, bus_cmd.data[7:0]};
            end else if (bus_cmd.write) begin
                write_pending = 1'b1;
                write_addr    = table_model[bus_cmd.addr];
                write_data    = bus_cmd.data[`CORE_DATA_WIDTH-1:0];
            end
            if (dma_read_ready && read_req.valid && read_req.addr != '0) begin
                stream_slot = '{busy: 1'b1, due: edge_count + 2, logical: read_req.addr,
                                physical: table_model[read_req.addr]};
            end
            if (bus_read_ready && bus_cmd.read) begin
                bus_slot = '{busy: 1'b1, due: edge_count + 1, logical: bus_cmd.addr,
                             physical: table_model[bus_cmd.addr]};
            end
            // Loads are visible to lookups from the next cycle on
            if (map_load.valid) begin
                table_model[map_load.logical] = map_load.physical;
            end
        end
    end

endmodule

/* tb_clock_gen.sv */
// Free-running 10 ns clock; reset is held low for the first 16 rising edges and then released
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

/* tb_top.sv */
// Drives the subsystem on rising edges; every wait for a ready or for reset gives up after a bound
`include "core_io_defines.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;
    import stream_pkg::*;

    localparam int WAIT_LIMIT = 64;

    logic clock;
    logic reset;
    bus_cmd_t bus_cmd;
    logic bus_read_ready;
    bus_rsp_t bus_rsp;
    map_write_t map_load;
    dma_write_t dma_write;
    read_req_t read_req;
    logic dma_read_ready;
    read_rsp_t read_rsp;
    int check_count;
    int mismatch_count;
    int protocol_count;

    tb_clock_gen clock_source (.clock(clock), .reset(reset));

    core_io_subsystem uut (
        .clock          (clock),
        .reset          (reset),
        .bus_cmd        (bus_cmd),
        .bus_read_ready (bus_read_ready),
        .bus_rsp        (bus_rsp),
        .map_load       (map_load),
        .dma_write      (dma_write),
        .read_req       (read_req),
        .dma_read_ready (dma_read_ready),
        .read_rsp       (read_rsp)
    );

    tb_checker response_checker (
        .clock          (clock),
        .reset          (reset),
        .bus_cmd        (bus_cmd),
        .bus_read_ready (bus_read_ready),
        .bus_rsp        (bus_rsp),
        .map_load       (map_load),
        .dma_write      (dma_write),
        .read_req       (read_req),
        .dma_read_ready (dma_read_ready),
        .read_rsp       (read_rsp),
        .check_count    (check_count),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count)
    );

    task automatic abort_run(input string reason);
        $display("%0t: %s", $time, reason);
        $display("Test FAILED");
        $finish;
    endtask

    // One-cycle write strobes on either requester, or both in the same cycle
    task automatic issue_writes(input logic stream_en, input logic [5:0] stream_dest,
                                input logic [19:0] stream_value, input logic bus_en,
                                input logic [5:0] bus_addr, input logic [31:0] bus_value);
        @(posedge clock);
        dma_write     <= '{valid: stream_en, dest: stream_dest, data: stream_value};
        bus_cmd.write <= bus_en;
        bus_cmd.addr  <= bus_addr;
        bus_cmd.data  <= bus_value;
        @(posedge clock);
        dma_write.valid <= 1'b0;
        bus_cmd.write   <= 1'b0;
    endtask

    task automatic load_entry(input logic [5:0] from_addr, input logic [5:0] to_entry);
        @(posedge clock);
        map_load <= '{valid: 1'b1, physical: to_entry, logical: from_addr};
        @(posedge clock);
        map_load.valid <= 1'b0;
    endtask

    // Holds the request until the handshake
    task automatic await_accept(input logic from_stream);
        int waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clock);
            if (from_stream) begin
                accepted = dma_read_ready && read_req.valid;
            end else begin
                accepted = bus_read_ready && bus_cmd.read;
            end
            waited++;
        end
        if (!accepted) begin
            abort_run("a read request was never accepted");
        end
        if (from_stream) begin
            read_req.valid <= 1'b0;
        end else begin
            bus_cmd.read <= 1'b0;
        end
    endtask

    task automatic issue_read(input logic from_stream, input logic [5:0] logical);
        @(posedge clock);
        if (from_stream) begin
            read_req <= '{valid: 1'b1, addr: logical};
        end else begin
            bus_cmd.read <= 1'b1;
            bus_cmd.addr <= logical;
        end
        await_accept(from_stream);
    endtask

    task automatic contend_reads(input logic [5:0] stream_addr, input logic [5:0] bus_addr);
        @(posedge clock);
        read_req     <= '{valid: 1'b1, addr: stream_addr};
        bus_cmd.read <= 1'b1;
        bus_cmd.addr <= bus_addr;
        await_accept(1'b1);
        await_accept(1'b0);
    endtask

    initial begin
        logic [5:0] logical;
        int waited;
        bus_cmd   = '0;
        map_load  = '0;
        dma_write = '0;
        read_req  = '0;
        void'($urandom(32'h9f01_37fd));
        waited = 0;
        while (reset !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (reset !== 1'b1) begin
            abort_run("reset was never released");
        end

        // Stream writes through the transparent map read back on both requesters
        for (int i = 0; i < 16; i++) begin
            logical = 6'($urandom_range(63, 1));
            issue_writes(1'b1, logical, 20'($urandom), 1'b0, '0, '0);
            issue_read(1'b0, logical);
            issue_read(1'b1, logical);
        end
        // Bus writes carry upper bits that must not come back
        for (int i = 0; i < 6; i++) begin
            logical = 6'($urandom_range(63, 1));
            issue_writes(1'b0, '0, '0, 1'b1, logical, $urandom | 32'hfff0_0000);
            issue_read(1'b0, logical);
            issue_read(1'b1, logical);
        end

        // Logical 5 and 6 alias physical 40
        load_entry(6'd5, 6'd40);
        load_entry(6'd6, 6'd40);
        issue_writes(1'b1, 6'd5, 20'ha5a5a, 1'b0, '0, '0);
        issue_read(1'b0, 6'd6);
        issue_read(1'b1, 6'd40);
        issue_writes(1'b0, '0, '0, 1'b1, 6'd6, 32'h0001_2345);
        issue_read(1'b1, 6'd5);

        // Unmapped logical address
        load_entry(6'd7, 6'd0);
        issue_writes(1'b1, 6'd7, 20'hfffff, 1'b0, '0, '0);
        issue_writes(1'b0, '0, '0, 1'b1, 6'd7, 32'h000b_eef0);
        issue_read(1'b0, 6'd7);
        issue_read(1'b1, 6'd7);

        // Configuration word starts at zero and a stream read of address 0 gets no response
        issue_read(1'b0, 6'd0);
        issue_writes(1'b0, '0, '0, 1'b1, 6'd0, 32'h1234_ff05);
        issue_read(1'b0, 6'd0);
        issue_read(1'b1, 6'd0);
        issue_read(1'b0, 6'd0);

        // Stream wins both the write and the read arbitration
        issue_writes(1'b1, 6'd11, 20'h11111, 1'b0, '0, '0);
        issue_writes(1'b1, 6'd10, 20'h22222, 1'b1, 6'd11, 32'h0003_3333);
        issue_read(1'b0, 6'd11);
        contend_reads(6'd10, 6'd11);

        waited = 0;
        while (!(bus_read_ready && dma_read_ready) && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (!(bus_read_ready && dma_read_ready)) begin
            abort_run("read sequencer never returned to idle");
        end
        repeat (4) @(posedge clock);
        $display("checks %0d, data mismatches %0d, protocol errors %0d",
                 check_count, mismatch_count, protocol_count);
        if (check_count > 0 && mismatch_count + protocol_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
bus_pkg.sv
stream_pkg.sv
io_translation_table.sv
register_file.sv
dma_endpoint.sv
core_io_subsystem.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv
